// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_hl_ds_top
FILELIST   := filelist.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
OBJ_DIR    := obj_dir
PASS_MSG   := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== ds_frame_parser.sv ====
module ds_frame_parser
  import hl_ds_pkg::*;
(
  input  logic      clk_ctrl,
  input  logic      reset_i,

  input  logic      eth_valid_i,
  input  byte_t     eth_data_i,

  output logic      cmd_strobe_o,
  output cmd_addr_t cmd_addr_o,
  output cmd_data_t cmd_data_o,
  output logic      cmd_ptt_o,

  output logic      iq_wr_o,
  output iq_word_u  iq_word_o
);

  logic [2:0]        state_q;
  logic [2:0]        cnt_q;
  logic [SAMP_W-1:0] samp_q;

  byte_t             hdr_exp;
  logic              in_cmd;
  logic              in_iq;

  // command shadow, copied out only once C4 is in
  cmd_addr_t         addr_sh;
  logic              ptt_sh;
  logic [23:0]       data_sh;

  always_comb begin
    case (cnt_q[1:0])
      2'd0:    hdr_exp = HDR_BYTE0;
      2'd1:    hdr_exp = HDR_BYTE1;
      2'd2:    hdr_exp = HDR_BYTE2;
      default: hdr_exp = EP_TX;
    endcase
  end

  assign in_cmd = eth_valid_i && (state_q == PS_CMD);
  assign in_iq  = eth_valid_i && (state_q == PS_IQ);

  //////////////////////////////////////////////////
  // frame fsm

  always_ff @(posedge clk_ctrl) begin
    cmd_strobe_o <= 1'b0;
    iq_wr_o      <= 1'b0;
    if (reset_i) begin
      state_q   <= PS_HDR;
      cnt_q     <= '0;
      samp_q    <= '0;
      cmd_ptt_o <= 1'b0;
    end else if (!eth_valid_i) begin
      // end of frame, back to idle
      state_q <= PS_HDR;
      cnt_q   <= '0;
      samp_q  <= '0;
    end else begin
      case (state_q)
        PS_HDR: begin
          if (eth_data_i != hdr_exp) begin
            state_q <= PS_DROP;
          end else if (cnt_q == 3'd3) begin
            state_q <= PS_SYNC;
            cnt_q   <= '0;
          end else begin
            cnt_q <= cnt_q + 3'd1;
          end
        end
        PS_SYNC: begin
          if (eth_data_i != SYNC_BYTE) begin
            state_q <= PS_DROP;
          end else if (cnt_q == 3'd2) begin
            state_q <= PS_CMD;
            cnt_q   <= '0;
          end else begin
            cnt_q <= cnt_q + 3'd1;
          end
        end
        PS_CMD: begin
          if (cnt_q == 3'd4) begin
            state_q      <= PS_IQ;
            cnt_q        <= '0;
            cmd_strobe_o <= 1'b1;
            cmd_ptt_o    <= ptt_sh;
          end else begin
            cnt_q <= cnt_q + 3'd1;
          end
        end
        PS_IQ: begin
          // 8 bytes per sample, counter wraps on its own
          cnt_q <= cnt_q + 3'd1;
          if (cnt_q == 3'd7) begin
            iq_wr_o <= 1'b1;
            samp_q  <= samp_q + 1'b1;
            if (samp_q == SAMP_W'(SAMPLES_PER_FRAME - 1)) begin
              state_q <= PS_DROP;
            end
          end
        end
        default: begin
          // bad header or trailing bytes, wait for valid to fall
          state_q <= PS_DROP;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // command and i/q datapath

  always_ff @(posedge clk_ctrl) begin
    if (in_cmd) begin
      case (cnt_q)
        3'd0: begin
          // C0 bit 7 is not used
          addr_sh <= eth_data_i[6:1];
          ptt_sh  <= eth_data_i[0];
        end
        3'd4: begin
          cmd_addr_o <= addr_sh;
          cmd_data_o <= {data_sh, eth_data_i};
        end
        default: data_sh <= {data_sh[15:0], eth_data_i};
      endcase
    end
    // bytes 4..7 of a sample are I hi/lo, Q hi/lo
    if (in_iq && cnt_q[2]) begin
      iq_word_o.bytes <= {iq_word_o.bytes[2:0], eth_data_i};
    end
  end

endmodule

// ==== ds_iq_fifo.sv ====
module ds_iq_fifo
  import hl_ds_pkg::*;
(
  input  logic     clk_ctrl,
  input  logic     reset_i,

  input  logic     wr_en_i,
  input  iq_word_u wr_word_i,

  input  logic     rd_en_i,
  output iq_word_u rd_word_o,

  output logic     empty_o,
  output logic     overflow_o
);

  iq_word_u         mem [FIFO_DEPTH];

  // extra msb tells full from empty
  logic [FIFO_AW:0] wr_ptr_q;
  logic [FIFO_AW:0] rd_ptr_q;

  logic             full;
  logic             wr_ok;
  logic             rd_ok;

  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full    = (wr_ptr_q[FIFO_AW] != rd_ptr_q[FIFO_AW]) &&
                   (wr_ptr_q[FIFO_AW-1:0] == rd_ptr_q[FIFO_AW-1:0]);

  assign wr_ok = wr_en_i && !full;
  assign rd_ok = rd_en_i && !empty_o;

  always_ff @(posedge clk_ctrl) begin
    if (wr_ok) begin
      mem[wr_ptr_q[FIFO_AW-1:0]] <= wr_word_i;
    end
  end

  // registered read, word shows up the cycle after rd_en
  always_ff @(posedge clk_ctrl) begin
    if (rd_ok) begin
      rd_word_o <= mem[rd_ptr_q[FIFO_AW-1:0]];
    end
  end

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (wr_ok) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // sample lost, sticky until reset
      if (wr_en_i && full) begin
        overflow_o <= 1'b1;
      end
    end
  end

endmodule

// ==== filelist.f ====
hl_ds_pkg.sv
ds_frame_parser.sv
ds_iq_fifo.sv
tx_sample_pacer.sv
hl_ds_top.sv
tb_hl_ds_top.sv

// ==== hl_ds_pkg.sv ====
package hl_ds_pkg;

  //////////////////////////////////////////////////
  // basic types

  typedef logic [7:0] byte_t;

  localparam int CMD_ADDR_W = 6;

  typedef logic [CMD_ADDR_W-1:0] cmd_addr_t;
  typedef logic [31:0]           cmd_data_t;

  // one fifo word, packed bytes in, signed i/q out
  // first byte on the wire lands in bytes[3]
  typedef union packed {
    byte_t [3:0] bytes;
    struct packed {
      logic signed [15:0] i;
      logic signed [15:0] q;
    } iq;
  } iq_word_u;

  //////////////////////////////////////////////////
  // frame format

  localparam byte_t HDR_BYTE0 = 8'hEF;
  localparam byte_t HDR_BYTE1 = 8'hFE;
  localparam byte_t HDR_BYTE2 = 8'h01;
  localparam byte_t EP_TX     = 8'h02;
  localparam byte_t SYNC_BYTE = 8'h7F;

  localparam int SAMPLES_PER_FRAME = 8;
  localparam int SAMP_W            = $clog2(SAMPLES_PER_FRAME);

  // parser phases, PS_HDR also serves as idle between frames
  localparam logic [2:0] PS_HDR  = 3'd0;
  localparam logic [2:0] PS_SYNC = 3'd1;
  localparam logic [2:0] PS_CMD  = 3'd2;
  localparam logic [2:0] PS_IQ   = 3'd3;
  localparam logic [2:0] PS_DROP = 3'd4;

  //////////////////////////////////////////////////
  // buffering and dac pacing

  localparam int FIFO_DEPTH    = 32;
  localparam int FIFO_AW       = 5;
  localparam int SAMPLE_PERIOD = 4;
  localparam int TICK_W        = $clog2(SAMPLE_PERIOD);

endpackage

// ==== hl_ds_top.sv ====
module hl_ds_top
  import hl_ds_pkg::*;
(
  input  logic               clk_ctrl,
  input  logic               reset_i,

  // byte stream from the udp receiver
  input  logic               eth_valid_i,
  input  byte_t              eth_data_i,

  output logic               cmd_strobe_o,
  output cmd_addr_t          cmd_addr_o,
  output cmd_data_t          cmd_data_o,
  output logic               cmd_ptt_o,

  // dac side
  output logic               tx_valid_o,
  output logic signed [15:0] tx_i_o,
  output logic signed [15:0] tx_q_o,

  output logic               overflow_o,
  output logic               underflow_o
);

  logic     iq_wr;
  iq_word_u iq_wr_word;
  logic     iq_rd;
  iq_word_u iq_rd_word;
  logic     iq_empty;

  //////////////////////////////////////////////////
  // frame parsing

  ds_frame_parser ds_frame_parser_i (
    .clk_ctrl     (clk_ctrl),
    .reset_i      (reset_i),
    .eth_valid_i  (eth_valid_i),
    .eth_data_i   (eth_data_i),
    .cmd_strobe_o (cmd_strobe_o),
    .cmd_addr_o   (cmd_addr_o),
    .cmd_data_o   (cmd_data_o),
    .cmd_ptt_o    (cmd_ptt_o),
    .iq_wr_o      (iq_wr),
    .iq_word_o    (iq_wr_word)
  );

  ds_iq_fifo ds_iq_fifo_i (
    .clk_ctrl   (clk_ctrl),
    .reset_i    (reset_i),
    .wr_en_i    (iq_wr),
    .wr_word_i  (iq_wr_word),
    .rd_en_i    (iq_rd),
    .rd_word_o  (iq_rd_word),
    .empty_o    (iq_empty),
    .overflow_o (overflow_o)
  );

  //////////////////////////////////////////////////
  // transmit pacing, ptt keys the pacer

  tx_sample_pacer tx_sample_pacer_i (
    .clk_ctrl     (clk_ctrl),
    .reset_i      (reset_i),
    .tx_on_i      (cmd_ptt_o),
    .fifo_empty_i (iq_empty),
    .fifo_rd_o    (iq_rd),
    .fifo_word_i  (iq_rd_word),
    .tx_valid_o   (tx_valid_o),
    .tx_i_o       (tx_i_o),
    .tx_q_o       (tx_q_o),
    .underflow_o  (underflow_o)
  );

endmodule

// ==== tb_hl_ds_top.sv ====
module tb_hl_ds_top
  import hl_ds_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // header, sync and command bytes come before the samples
  localparam int FRAME_BYTES = 12 + 8 * SAMPLES_PER_FRAME;
  localparam int N_FRAMES    = 20 + 6 + 7 + 10 + 6;
  localparam int MAX_CYCLES  = N_FRAMES * (FRAME_BYTES + 2) +
                               N_FRAMES * SAMPLES_PER_FRAME * SAMPLE_PERIOD + 2000;

  logic               clk_ctrl = 1'b0;
  logic               reset_i;
  logic               eth_valid_i;
  byte_t              eth_data_i;
  logic               cmd_strobe_o;
  cmd_addr_t          cmd_addr_o;
  cmd_data_t          cmd_data_o;
  logic               cmd_ptt_o;
  logic               tx_valid_o;
  logic signed [15:0] tx_i_o;
  logic signed [15:0] tx_q_o;
  logic               overflow_o;
  logic               underflow_o;

  // reference model
  cmd_addr_t exp_addr_q [$];
  cmd_data_t exp_data_q [$];
  logic      exp_ptt_q [$];
  iq_word_u  exp_iq_q [$];
  logic      exp_ovf;
  logic      model_ptt;

  int errors = 0;
  int checks = 0;
  int test_base = 0;
  int samples_seen = 0;
  int cycle_cnt = 0;

  hl_ds_top hl_ds_top_i (.*);

  always #10 clk_ctrl = ~clk_ctrl;

  //////////////////////////////////////////////////
  // compare tasks

  task automatic check_cmd(input cmd_addr_t addr, input cmd_data_t data, input logic ptt);
    checks++;
    if (exp_addr_q.size() == 0) begin
      errors++;
      $display("command strobe seen while no command was expected");
    end else begin
      if (addr !== exp_addr_q[0]) begin
        errors++;
        $display("mismatch cmd_addr_o: got %h expected %h", addr, exp_addr_q[0]);
      end
      if (data !== exp_data_q[0]) begin
        errors++;
        $display("mismatch cmd_data_o: got %h expected %h", data, exp_data_q[0]);
      end
      if (ptt !== exp_ptt_q[0]) begin
        errors++;
        $display("mismatch cmd_ptt_o: got %h expected %h", ptt, exp_ptt_q[0]);
      end
      void'(exp_addr_q.pop_front());
      void'(exp_data_q.pop_front());
      void'(exp_ptt_q.pop_front());
    end
  endtask

  task automatic check_sample(input iq_word_u got);
    iq_word_u exp;
    checks++;
    samples_seen++;
    if (exp_iq_q.size() == 0) begin
      errors++;
      $display("tx sample seen while no sample was expected");
    end else begin
      exp = exp_iq_q.pop_front();
      if (got.iq.i !== exp.iq.i) begin
        errors++;
        $display("mismatch tx_i_o: got %h expected %h", got.iq.i, exp.iq.i);
      end
      if (got.iq.q !== exp.iq.q) begin
        errors++;
        $display("mismatch tx_q_o: got %h expected %h", got.iq.q, exp.iq.q);
      end
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  // registered outputs seen one edge after they change
  always @(posedge clk_ctrl) begin : monitor
    iq_word_u got;
    if (!reset_i && cmd_strobe_o)
      check_cmd(cmd_addr_o, cmd_data_o, cmd_ptt_o);
    if (!reset_i && tx_valid_o) begin
      got.iq.i = tx_i_o;
      got.iq.q = tx_q_o;
      check_sample(got);
    end
  end

  always @(posedge clk_ctrl) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, expected output never arrived", cycle_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // stimulus

  task automatic apply_reset();
    @(posedge clk_ctrl);
    #2;
    reset_i     = 1'b1;
    eth_valid_i = 1'b0;
    eth_data_i  = '0;
    repeat (16) @(posedge clk_ctrl);
    #2;
    reset_i = 1'b0;
    exp_addr_q.delete();
    exp_data_q.delete();
    exp_ptt_q.delete();
    exp_iq_q.delete();
    exp_ovf      = 1'b0;
    model_ptt    = 1'b0;
    samples_seen = 0;
  endtask

  task automatic drive_byte(input byte_t b);
    @(posedge clk_ctrl);
    #2;
    eth_valid_i = 1'b1;
    eth_data_i  = b;
  endtask

  task automatic end_frame();
    @(posedge clk_ctrl);
    #2;
    eth_valid_i = 1'b0;
    eth_data_i  = '0;
    @(posedge clk_ctrl);
  endtask

  // sends len bytes of one frame and corrupts byte bad_idx when it is not negative
  task automatic send_frame(input int len, input int bad_idx, input logic ptt);
    byte_t     fb [FRAME_BYTES];
    cmd_addr_t addr;
    cmd_data_t data;
    iq_word_u  w;
    addr  = cmd_addr_t'($urandom);
    data  = $urandom;
    fb[0] = HDR_BYTE0;
    fb[1] = HDR_BYTE1;
    fb[2] = HDR_BYTE2;
    fb[3] = EP_TX;
    for (int k = 4; k < 7; k++) fb[k] = SYNC_BYTE;
    // bit 7 of C0 is random and must be ignored
    fb[7] = {1'($urandom), addr, ptt};
    for (int k = 0; k < 4; k++) fb[8 + k] = data[31 - 8 * k -: 8];
    for (int k = 12; k < FRAME_BYTES; k++) fb[k] = byte_t'($urandom);
    if (bad_idx >= 0) fb[bad_idx] = fb[bad_idx] ^ byte_t'($urandom_range(255, 1));
    for (int k = 0; k < len; k++) begin
      drive_byte(fb[k]);
      if (bad_idx < 0 && k == 11) begin
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
        exp_ptt_q.push_back(ptt);
        model_ptt = ptt;
      end
      // Q lo completes a sample with i and q as big-endian pairs
      if (bad_idx < 0 && k >= 12 && (k - 12) % 8 == 7) begin
        w.iq.i = {fb[k - 3], fb[k - 2]};
        w.iq.q = {fb[k - 1], fb[k]};
        if (exp_iq_q.size() < FIFO_DEPTH) exp_iq_q.push_back(w);
        else exp_ovf = 1'b1;
      end
    end
    end_frame();
  endtask

  task automatic wait_idle();
    while (exp_addr_q.size() != 0) @(posedge clk_ctrl);
    while (model_ptt && exp_iq_q.size() != 0) @(posedge clk_ctrl);
    repeat (4 * SAMPLE_PERIOD) @(posedge clk_ctrl);
  endtask

  task automatic finish_test(input string name);
    check_flag("overflow_o", overflow_o, exp_ovf);
    $display("test %-30s %0d errors", name, errors - test_base);
    test_base = errors;
  endtask

  //////////////////////////////////////////////////
  // test sequence

  initial begin
    int len;
    reset_i     = 1'b1;
    eth_valid_i = 1'b0;
    eth_data_i  = '0;
    void'($urandom(73581));

    apply_reset();
    for (int n = 0; n < 20; n++) send_frame(FRAME_BYTES, -1, 1'b0);
    wait_idle();
    checks++;
    if (samples_seen != 0) begin
      errors++;
      $display("tx_valid_o pulsed %0d times while ptt was off", samples_seen);
    end
    finish_test("commands with ptt off");

    apply_reset();
    for (int n = 0; n < 6; n++) send_frame(FRAME_BYTES, -1, 1'b1);
    wait_idle();
    finish_test("samples with ptt on");

    // one frame per header, endpoint and sync position
    apply_reset();
    for (int n = 0; n < 7; n++) send_frame(FRAME_BYTES, n, 1'($urandom));
    wait_idle();
    finish_test("bad header, endpoint or sync");

    apply_reset();
    for (int n = 0; n < 10; n++) begin
      len = $urandom_range(FRAME_BYTES, 1);
      send_frame(len, -1, 1'($urandom));
    end
    wait_idle();
    finish_test("truncated frames");

    apply_reset();
    for (int n = 0; n < 5; n++) send_frame(FRAME_BYTES, -1, 1'b0);
    wait_idle();
    check_flag("overflow_o", overflow_o, 1'b1);
    check_flag("underflow_o", underflow_o, 1'b0);
    send_frame(12, -1, 1'b1);
    wait_idle();
    check_flag("underflow_o", underflow_o, 1'b1);
    if (samples_seen != FIFO_DEPTH) begin
      errors++;
      $display("drain gave %0d samples instead of a full fifo", samples_seen);
    end
    finish_test("overflow, drain and underflow");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== tx_sample_pacer.sv ====
module tx_sample_pacer
  import hl_ds_pkg::*;
(
  input  logic               clk_ctrl,
  input  logic               reset_i,

  input  logic               tx_on_i,

  input  logic               fifo_empty_i,
  output logic               fifo_rd_o,
  input  iq_word_u           fifo_word_i,

  output logic               tx_valid_o,
  output logic signed [15:0] tx_i_o,
  output logic signed [15:0] tx_q_o,

  output logic               underflow_o
);

  logic [TICK_W-1:0] tick_cnt_q;
  logic              tick;

  //////////////////////////////////////////////////
  // dac sample tick

  assign tick = (tick_cnt_q == TICK_W'(SAMPLE_PERIOD - 1));

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      tick_cnt_q <= '0;
    end else if (tick) begin
      tick_cnt_q <= '0;
    end else begin
      tick_cnt_q <= tick_cnt_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // pop and output

  // one pop per tick at most
  assign fifo_rd_o = tick && tx_on_i && !fifo_empty_i;

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      tx_valid_o  <= 1'b0;
      underflow_o <= 1'b0;
    end else begin
      // fifo word lands together with this
      tx_valid_o <= fifo_rd_o;
      if (tick && tx_on_i && fifo_empty_i) begin
        underflow_o <= 1'b1;
      end
    end
  end

  // fifo output holds until the next pop
  assign tx_i_o = fifo_word_i.iq.i;
  assign tx_q_o = fifo_word_i.iq.q;

endmodule
